/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the hazard unit testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module hazard_tb \
    --Mdir obj_dir -o Vhazard_tb \
    -f sources.f

./obj_dir/Vhazard_tb | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "run_sim: testbench reported failure"
    exit 1
fi

if ! grep -q "Simulation passed" "$LOG"; then
    echo "run_sim: no pass message in $LOG"
    exit 1
fi

/* sources.f */
src/hazard_pkg.sv
src/stage_if.sv
src/dest_tracker.sv
src/operand_hazard.sv
src/hazard_resolve.sv
src/hazard_unit_top.sv
testbench/hazard_checker.sv
testbench/hazard_monitor.sv
testbench/hazard_tb.sv

/* src/dest_tracker.sv */
module dest_tracker import hazard_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      id_valid,
    input  logic                      stall,
    input  logic [REG_ADDR_WIDTH-1:0] id_rd,
    input  dest_kind_e                id_dest_kind,
    stage_if.tracker                  stages
);

    logic                      bubble;
    dest_kind_e                ex_kind_d;

    dest_kind_e                ex_kind_q;
    dest_kind_e                mem_kind_q;
    dest_kind_e                wb_kind_q;

    logic [REG_ADDR_WIDTH-1:0] ex_rd_q;
    logic [REG_ADDR_WIDTH-1:0] mem_rd_q;
    logic [REG_ADDR_WIDTH-1:0] wb_rd_q;

    // ******************************
    // next EX record
    // ******************************

    // ID held back or empty, so EX gets a bubble.
    assign bubble = !id_valid || stall;

    // a write to x0 is dropped here, it can never be forwarded.
    always_comb begin
        if (bubble) begin
            ex_kind_d = DEST_NONE;
        end else if (id_rd == '0) begin
            ex_kind_d = DEST_NONE;
        end else begin
            ex_kind_d = id_dest_kind;
        end
    end

    // ******************************
    // stage registers
    // ******************************

    // kinds decide whether a record is live.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_kind_q  <= DEST_NONE;
            mem_kind_q <= DEST_NONE;
            wb_kind_q  <= DEST_NONE;
        end else begin
            ex_kind_q  <= ex_kind_d;
            mem_kind_q <= ex_kind_q;
            wb_kind_q  <= mem_kind_q;
        end
    end

    // destination addresses move along with the kinds.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_rd_q  <= '0;
            mem_rd_q <= '0;
            wb_rd_q  <= '0;
        end else begin
            if (bubble) begin
                ex_rd_q <= '0;
            end else begin
                ex_rd_q <= id_rd;
            end
            mem_rd_q <= ex_rd_q;
            wb_rd_q  <= mem_rd_q;
        end
    end

    // ******************************
    // record outputs
    // ******************************

    assign stages.ex_rd    = ex_rd_q;
    assign stages.ex_kind  = ex_kind_q;
    assign stages.mem_rd   = mem_rd_q;
    assign stages.mem_kind = mem_kind_q;
    assign stages.wb_rd    = wb_rd_q;
    assign stages.wb_kind  = wb_kind_q;

endmodule

/* src/hazard_pkg.sv */
package hazard_pkg;

    // ******************************
    // register addressing
    // ******************************

    // x0 is hardwired to zero, so address zero never carries a dependency.
    localparam int REG_ADDR_WIDTH = 5;

    // ******************************
    // destination kind
    // ******************************

    // what the instruction held in a stage writes back.
    // none also covers bubbles, stores and branches.
    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        // result ready at the end of EX.
        DEST_ALU  = 2'd1,
        // result ready only at the end of MEM.
        DEST_LOAD = 2'd2
    } dest_kind_e;

    // ******************************
    // forwarding source
    // ******************************

    // operand mux select in front of the ALU.
    typedef enum logic [1:0] {
        // value read from the register file.
        FWD_NONE = 2'd0,
        // EX/MEM result register.
        FWD_EX   = 2'd1,
        // MEM/WB result register.
        FWD_MEM  = 2'd2,
        // value being written back this cycle.
        FWD_WB   = 2'd3
    } fwd_src_e;

endpackage

/* src/hazard_resolve.sv */
module hazard_resolve import hazard_pkg::*; #(
    parameter int NUM_OPERANDS = 2
) (
    input  logic                          id_valid,
    input  fwd_src_e [NUM_OPERANDS-1:0]   fwd_src,
    input  logic     [NUM_OPERANDS-1:0]   load_use,
    output logic                          stall,
    output fwd_src_e [NUM_OPERANDS-1:0]   fwd_sel
);

    logic any_load_use;

    // ******************************
    // stall
    // ******************************

    // one waiting operand is enough to hold the whole instruction.
    assign any_load_use = |load_use;
    assign stall        = id_valid && any_load_use;

    // ******************************
    // forwarding selects
    // ******************************

    // a held or empty slot reads plain register file values.
    always_comb begin
        for (int i = 0; i < NUM_OPERANDS; i++) begin
            if (stall || !id_valid) begin
                fwd_sel[i] = FWD_NONE;
            end else begin
                fwd_sel[i] = fwd_src[i];
            end
        end
    end

endmodule

/* src/hazard_unit_top.sv */
module hazard_unit_top import hazard_pkg::*; #(
    parameter int NUM_OPERANDS = 2
) (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         id_valid,
    input  logic     [NUM_OPERANDS-1:0][REG_ADDR_WIDTH-1:0] id_rs_addr,
    input  logic     [NUM_OPERANDS-1:0]                  id_rs_used,
    input  logic     [REG_ADDR_WIDTH-1:0]                id_rd,
    input  dest_kind_e                                   id_dest_kind,
    output logic                                         stall,
    output fwd_src_e [NUM_OPERANDS-1:0]                  fwd_sel
);

    fwd_src_e [NUM_OPERANDS-1:0] fwd_src;
    logic     [NUM_OPERANDS-1:0] load_use;

    // EX, MEM and WB destination records.
    stage_if stages ();

    // ******************************
    // destination tracking
    // ******************************

    dest_tracker tracker_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .id_valid     (id_valid),
        .stall        (stall),
        .id_rd        (id_rd),
        .id_dest_kind (id_dest_kind),
        .stages       (stages.tracker)
    );

    // ******************************
    // per-operand checks
    // ******************************

    for (genvar g = 0; g < NUM_OPERANDS; g++) begin : g_operand
        operand_hazard operand_hazard_i (
            .rs_addr  (id_rs_addr[g]),
            .rs_used  (id_rs_used[g]),
            .stages   (stages.reader),
            .fwd_src  (fwd_src[g]),
            .load_use (load_use[g])
        );
    end

    // stall and final selects.
    hazard_resolve #(
        .NUM_OPERANDS (NUM_OPERANDS)
    ) resolve_i (
        .id_valid (id_valid),
        .fwd_src  (fwd_src),
        .load_use (load_use),
        .stall    (stall),
        .fwd_sel  (fwd_sel)
    );

endmodule

/* src/operand_hazard.sv */
module operand_hazard import hazard_pkg::*; (
    input  logic [REG_ADDR_WIDTH-1:0] rs_addr,
    input  logic                      rs_used,
    stage_if.reader                   stages,
    output fwd_src_e                  fwd_src,
    output logic                      load_use
);

    logic live;
    logic hit_ex;
    logic hit_mem;
    logic hit_wb;

    // a stage produces the operand when it writes a real register
    // and that register is the one being read.
    function automatic logic stage_hit(
        input dest_kind_e                kind,
        input logic [REG_ADDR_WIDTH-1:0] rd,
        input logic [REG_ADDR_WIDTH-1:0] rs
    );
        return (kind != DEST_NONE) && (rd != '0) && (rd == rs);
    endfunction

    // ******************************
    // stage comparison
    // ******************************

    // x0 and unused fields never depend on anything.
    assign live = rs_used && (rs_addr != '0);

    assign hit_ex  = live && stage_hit(stages.ex_kind, stages.ex_rd, rs_addr);
    assign hit_mem = live && stage_hit(stages.mem_kind, stages.mem_rd, rs_addr);
    assign hit_wb  = live && stage_hit(stages.wb_kind, stages.wb_rd, rs_addr);

    // ******************************
    // priority select
    // ******************************

    // youngest producer wins: EX, then MEM, then WB.
    always_comb begin
        fwd_src  = FWD_NONE;
        load_use = 1'b0;
        if (hit_ex) begin
            if (stages.ex_kind == DEST_LOAD) begin
                // load data not there yet, wait one cycle.
                load_use = 1'b1;
            end else begin
                fwd_src = FWD_EX;
            end
        end else if (hit_mem) begin
            fwd_src = FWD_MEM;
        end else if (hit_wb) begin
            fwd_src = FWD_WB;
        end
    end

endmodule

/* src/stage_if.sv */
interface stage_if import hazard_pkg::*; ();

    // destination record of the instruction in EX.
    logic [REG_ADDR_WIDTH-1:0] ex_rd;
    dest_kind_e                ex_kind;

    // destination record of the instruction in MEM.
    logic [REG_ADDR_WIDTH-1:0] mem_rd;
    dest_kind_e                mem_kind;

    // destination record of the instruction in WB.
    logic [REG_ADDR_WIDTH-1:0] wb_rd;
    dest_kind_e                wb_kind;

    // the tracker owns the records.
    modport tracker (
        output ex_rd,
        output ex_kind,
        output mem_rd,
        output mem_kind,
        output wb_rd,
        output wb_kind
    );

    // checkers only look at them.
    modport reader (
        input ex_rd,
        input ex_kind,
        input mem_rd,
        input mem_kind,
        input wb_rd,
        input wb_kind
    );

endinterface

/* testbench/hazard_checker.sv */
module hazard_checker import hazard_pkg::*; #(
    parameter int NUM_OPERANDS = 2
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        stall,
    input  fwd_src_e [NUM_OPERANDS-1:0] fwd_sel,
    input  dest_kind_e                  ex_kind,
    input  dest_kind_e                  mem_kind,
    input  dest_kind_e                  wb_kind
);

    // only a load sitting in EX can hold ID.
    stall_needs_load: assert property (
        @(posedge clk) disable iff (!arst_n) stall |-> (ex_kind == DEST_LOAD)
    ) else $error("stall is high without a load in EX");

    // a held instruction must not see forwarded values.
    for (genvar g = 0; g < NUM_OPERANDS; g++) begin : g_sel
        sel_idle_in_stall: assert property (
            @(posedge clk) disable iff (!arst_n) stall |-> (fwd_sel[g] == FWD_NONE)
        ) else $error("operand %0d forwards during a stall", g);
    end

    // first edge after reset release still sees empty stages.
    reset_clears_stages: assert property (
        @(posedge clk) $rose(arst_n) |->
            (ex_kind == DEST_NONE) && (mem_kind == DEST_NONE) && (wb_kind == DEST_NONE)
    ) else $error("stage records not empty after reset");

endmodule

bind hazard_unit_top hazard_checker #(
    .NUM_OPERANDS (NUM_OPERANDS)
) checker_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .stall    (stall),
    .fwd_sel  (fwd_sel),
    .ex_kind  (stages.ex_kind),
    .mem_kind (stages.mem_kind),
    .wb_kind  (stages.wb_kind)
);

/* testbench/hazard_monitor.sv */
module hazard_monitor import hazard_pkg::*; #(
    parameter int NUM_OPERANDS = 2
) (
    input  logic                        clk,
    input  logic                        check_en,
    input  logic                        stall,
    input  fwd_src_e [NUM_OPERANDS-1:0] fwd_sel,
    input  logic                        exp_stall,
    input  fwd_src_e [NUM_OPERANDS-1:0] exp_sel,
    output int                          error_count,
    output int                          check_count
);

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // ******************************
    // compare
    // ******************************

    // inputs change just after the rising edge, so the falling edge sees settled outputs.
    always @(negedge clk) begin
        if (check_en) begin
            checks = checks + 1;
            if (stall !== exp_stall) begin
                errors = errors + 1;
                $display("[ERROR] %0t stall: expected %0b, actual %0b",
                         $time, exp_stall, stall);
            end
            for (int i = 0; i < NUM_OPERANDS; i++) begin
                if (fwd_sel[i] !== exp_sel[i]) begin
                    errors = errors + 1;
                    $display("[ERROR] %0t fwd_sel[%0d]: expected %0d, actual %0d",
                             $time, i, exp_sel[i], fwd_sel[i]);
                end
            end
        end
    end

endmodule

/* testbench/hazard_tb.sv */
module hazard_tb import hazard_pkg::*; ();

    localparam int NUM_OPERANDS   = 2;
    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int TIMEOUT_MARGIN = 12;

    // one line of the test file.
    typedef struct packed {
        logic                                     valid;
        logic [NUM_OPERANDS-1:0][REG_ADDR_WIDTH-1:0] rs;
        logic [NUM_OPERANDS-1:0]                  used;
        logic [REG_ADDR_WIDTH-1:0]                rd;
        dest_kind_e                               kind;
        logic                                     stall;
        fwd_src_e [NUM_OPERANDS-1:0]              sel;
    } test_vec_t;

    logic                                        clk;
    logic                                        arst_n;
    logic                                        id_valid;
    logic     [NUM_OPERANDS-1:0][REG_ADDR_WIDTH-1:0] id_rs_addr;
    logic     [NUM_OPERANDS-1:0]                 id_rs_used;
    logic     [REG_ADDR_WIDTH-1:0]               id_rd;
    dest_kind_e                                  id_dest_kind;
    logic                                        stall;
    fwd_src_e [NUM_OPERANDS-1:0]                 fwd_sel;

    logic                        check_en;
    logic                        exp_stall;
    fwd_src_e [NUM_OPERANDS-1:0] exp_sel;
    int                          error_count;
    int                          check_count;
    test_vec_t                   tests[$];
    int                          num_vectors = 0;
    logic                        load_failed;

    hazard_unit_top #(
        .NUM_OPERANDS (NUM_OPERANDS)
    ) dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .id_valid     (id_valid),
        .id_rs_addr   (id_rs_addr),
        .id_rs_used   (id_rs_used),
        .id_rd        (id_rd),
        .id_dest_kind (id_dest_kind),
        .stall        (stall),
        .fwd_sel      (fwd_sel)
    );

    hazard_monitor #(
        .NUM_OPERANDS (NUM_OPERANDS)
    ) monitor_i (
        .clk         (clk),
        .check_en    (check_en),
        .stall       (stall),
        .fwd_sel     (fwd_sel),
        .exp_stall   (exp_stall),
        .exp_sel     (exp_sel),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ******************************
    // test file
    // ******************************

    task automatic load_tests();
        int        fd;
        int        code;
        int        fields;
        int        f [10];
        string     line;
        test_vec_t vec;
        load_failed = 1'b0;
        fd = $fopen("testbench/hazard_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/hazard_tests.txt");
            load_failed = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", f[0], f[1],
                                     f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    if (fields == 10) begin
                        vec.valid   = f[0][0];
                        vec.rs[0]   = f[1][REG_ADDR_WIDTH-1:0];
                        vec.rs[1]   = f[2][REG_ADDR_WIDTH-1:0];
                        vec.used[0] = f[3][0];
                        vec.used[1] = f[4][0];
                        vec.rd      = f[5][REG_ADDR_WIDTH-1:0];
                        vec.kind    = dest_kind_e'(f[6][1:0]);
                        vec.stall   = f[7][0];
                        vec.sel[0]  = fwd_src_e'(f[8][1:0]);
                        vec.sel[1]  = fwd_src_e'(f[9][1:0]);
                        tests.push_back(vec);
                    end else begin
                        $display("malformed line in test file: %s", line);
                        load_failed = 1'b1;
                    end
                end
            end
            $fclose(fd);
            if (tests.size() == 0) begin
                $display("test file holds no vectors");
                load_failed = 1'b1;
            end
        end
    endtask

    task automatic apply_vector(input test_vec_t v);
        id_valid     = v.valid;
        id_rs_addr   = v.rs;
        id_rs_used   = v.used;
        id_rd        = v.rd;
        id_dest_kind = v.kind;
        exp_stall    = v.stall;
        exp_sel      = v.sel;
        check_en     = 1'b1;
    endtask

    // ******************************
    // main sequence
    // ******************************

    initial begin
        arst_n       = 1'b0;
        id_valid     = 1'b0;
        id_rs_addr   = '0;
        id_rs_used   = '0;
        id_rd        = '0;
        id_dest_kind = DEST_NONE;
        exp_stall    = 1'b0;
        check_en     = 1'b0;
        for (int i = 0; i < NUM_OPERANDS; i++) begin
            exp_sel[i] = FWD_NONE;
        end
        load_tests();
        if (load_failed) begin
            $display("Simulation failed");
            $finish;
        end else begin
            num_vectors = tests.size();
            repeat (3) @(posedge clk);
            #(DRIVE_DELAY);
            arst_n = 1'b1;
            // a held vector repeats in the file, so every line is one cycle.
            foreach (tests[i]) begin
                apply_vector(tests[i]);
                @(posedge clk);
                #(DRIVE_DELAY);
            end
            check_en = 1'b0;
            if (check_count != num_vectors) begin
                $display("only %0d of %0d vectors were checked", check_count, num_vectors);
            end
            $display("checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0 && check_count == num_vectors) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // watchdog.
    initial begin
        wait (num_vectors > 0);
        #((num_vectors + TIMEOUT_MARGIN) * CLK_PERIOD);
        $display("run timed out before all test vectors were applied");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* testbench/hazard_tests.txt */
# columns: id_valid rs1 rs2 rs1_used rs2_used rd kind exp_stall exp_sel1 exp_sel2
# kind 0 none, 1 alu, 2 load; sel 0 regfile, 1 ex, 2 mem, 3 wb
1 1 2 1 1 3 1 0 0 0
1 3 0 1 0 4 1 0 1 0
1 5 3 1 1 6 1 0 0 2
1 3 4 1 1 7 1 0 3 2
1 1 2 1 1 8 2 0 0 0
1 8 6 1 1 9 1 1 0 0
1 8 6 1 1 9 1 0 2 0
1 9 8 1 1 0 1 0 1 3
1 0 9 1 0 10 1 0 0 0
1 10 11 1 1 11 0 0 1 0
1 11 10 1 1 12 1 0 0 2
1 0 0 0 0 13 2 0 0 0
1 13 12 0 1 14 1 0 0 2
1 13 12 1 1 15 1 0 2 3
1 0 0 0 0 15 1 0 0 0
1 15 14 1 1 16 1 0 1 3
1 15 16 1 1 17 2 0 2 1
1 16 17 1 1 18 1 1 0 0
1 16 17 1 1 18 1 0 3 2
0 18 17 1 1 19 1 0 0 0
1 18 0 1 0 20 2 0 2 0
0 20 20 1 1 21 1 0 0 0
1 21 20 1 1 22 1 0 0 2
1 19 20 1 1 0 0 0 0 3
1 22 0 1 1 23 1 0 2 0
1 22 23 1 1 24 2 0 3 1
1 24 24 1 1 25 1 1 0 0
1 24 24 1 1 25 1 0 2 2
1 24 25 1 1 0 1 0 3 1
0 0 0 0 0 0 0 0 0 0
